// ==== rename_core.f ====
hdl/rename_pkg.sv
hdl/rename_free_list.sv
hdl/register_file.sv
hdl/operand_fetch.sv
hdl/rename_core.sv
bench/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - hdl/rename_pkg.sv
  - hdl/rename_free_list.sv
  - hdl/register_file.sv
  - hdl/operand_fetch.sv
  - hdl/rename_core.sv
  - target: test
    files:
      - bench/rename_core_tb.sv

// ==== bench/rename_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb import rename_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 400;  // about 50 cycles of tests plus margin

  logic         global_bus;
  logic         rst_n;
  rename_req_t  ren_req [LANES];
  rename_rsp_t  ren_rsp [LANES];
  logic         ren_ready;
  wb_t          wb [LANES];
  operand_req_t rd_req [LANES];
  operand_t     rd_rsp [LANES];
  logic         clear_tag;
  logic         delete_tag;

  entry_t              model_regs [PHYS_REGS];
  entry_t              pend [PHYS_REGS];  // next state while the model is updated
  operand_t            model_op [LANES];  // read results as the operand registers hold them
  logic [REN_REGS-1:0] model_free;
  logic [REN_REGS-1:0] rel_mask;
  int                  errors;
  int                  checks;
  integer              seed;

  rename_core uut (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .ren_req    (ren_req),
    .ren_rsp    (ren_rsp),
    .ren_ready  (ren_ready),
    .wb         (wb),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .clear_tag  (clear_tag),
    .delete_tag (delete_tag)
  );

  always #50 global_bus = ~global_bus;

  task automatic check_rsp(input rename_rsp_t got, input rename_rsp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got rn %0d maps %0d %0d, expected rn %0d maps %0d %0d", $time,
               what, got.rn, got.rs_1_map, got.rs_2_map, exp.rn, exp.rs_1_map, exp.rs_2_map);
    end
  endtask

  task automatic check_operand(input operand_t got, input operand_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %h/%b %h/%b, expected %h/%b %h/%b", $time, what,
               got.data_1, got.valid_1, got.data_2, got.valid_2,
               exp.data_1, exp.valid_1, exp.data_2, exp.valid_2);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: ren_ready is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [REG_IDX_W-1:0] lookup(input logic [REG_IDX_W-1:0] idx);
    return (model_regs[idx].rrn != '0) ? model_regs[idx].rrn : idx;
  endfunction

  // k-th lowest free rename number, zero when there is none
  function automatic logic [REG_IDX_W-1:0] lowest_free(input int k);
    int n;
    n = 0;
    for (int i = 0; i < REN_REGS; i++) begin
      if (model_free[i]) begin
        if (n == k) return REG_IDX_W'(ARCH_REGS + i);
        n++;
      end
    end
    return '0;
  endfunction

  function automatic logic model_ready();
    return $countones(model_free) >= 2;
  endfunction

  function automatic logic [REG_IDX_W-1:0] rand_rd();
    return REG_IDX_W'(1 + {$random(seed)} % 31);
  endfunction

  function automatic logic [REG_IDX_W-1:0] first_mapped();
    for (int i = 1; i < ARCH_REGS; i++) begin
      if (model_regs[i].rrn != '0) return REG_IDX_W'(i);
    end
    return '0;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < PHYS_REGS; i++) begin
      model_regs[i] = '{value: '0, rrn: '0, valid: (i < ARCH_REGS), tag: 1'b0};
    end
    for (int l = 0; l < LANES; l++) begin
      model_op[l] = '0;
    end
    model_free = '1;
  endtask

  // writebacks and commits on pend, lane 1 last so it wins
  task automatic apply_wb();
    for (int l = 0; l < LANES; l++) begin
      if (wb[l].reg_write && wb[l].arn == '0) begin
        pend[wb[l].rrn].value = wb[l].result;
        pend[wb[l].rrn].valid = 1'b1;
      end else if (wb[l].reg_write) begin
        pend[wb[l].arn].value = wb[l].result;
        pend[wb[l].arn].valid = 1'b1;
        if (model_regs[wb[l].arn].rrn == wb[l].rrn) begin
          pend[wb[l].arn].rrn = '0;
          pend[wb[l].arn].tag = 1'b0;
        end
        pend[wb[l].rrn] = '0;
        rel_mask[int'(wb[l].rrn) - ARCH_REGS] = 1'b1;
      end
    end
  endtask

  task automatic model_update();
    logic [REN_REGS-1:0]  grab;
    logic [REG_IDX_W-1:0] rn;
    grab     = '0;
    rel_mask = '0;
    pend     = model_regs;
    if (delete_tag) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        if (model_regs[i].tag && i < ARCH_REGS) begin
          pend[i].rrn = '0;
          pend[i].tag = 1'b0;
        end else if (model_regs[i].tag) begin
          pend[i]                  = '0;
          rel_mask[i - ARCH_REGS] = 1'b1;
        end
      end
    end else if (clear_tag) begin
      for (int i = 0; i < PHYS_REGS; i++) pend[i].tag = 1'b0;
    end
    apply_wb();
    for (int l = 0; l < LANES; l++) begin
      rn = lowest_free(l);
      if (ren_req[l].valid && model_ready()) begin
        pend[ren_req[l].rd].rrn = rn;
        pend[ren_req[l].rd].tag = ren_req[l].tag;
        if (!ren_req[l].tag) pend[ren_req[l].rd].valid = 1'b0;
        pend[rn]     = '0;
        pend[rn].tag = ren_req[l].tag;
        grab[int'(rn) - ARCH_REGS] = 1'b1;
      end
    end
    model_regs = pend;
    model_free = (model_free & ~grab) | rel_mask;
  endtask

  task automatic idle();
    for (int l = 0; l < LANES; l++) begin
      ren_req[l] = '0;
      wb[l]      = '0;
      rd_req[l]  = '0;
    end
    clear_tag  = 1'b0;
    delete_tag = 1'b0;
  endtask

  task automatic set_ren(input int l, input logic spec, input logic [REG_IDX_W-1:0] rd,
                         input logic [REG_IDX_W-1:0] rs_1, input logic [REG_IDX_W-1:0] rs_2);
    ren_req[l] = '{valid: 1'b1, tag: spec, rd: rd, rs_1: rs_1, rs_2: rs_2};
  endtask

  task automatic set_lookup(input int l, input logic [REG_IDX_W-1:0] rs_1,
                            input logic [REG_IDX_W-1:0] rs_2);
    ren_req[l] = '{valid: 1'b0, tag: 1'b0, rd: '0, rs_1: rs_1, rs_2: rs_2};
  endtask

  task automatic set_read(input int l, input logic [REG_IDX_W-1:0] s_1,
                          input logic [REG_IDX_W-1:0] s_2);
    rd_req[l] = '{rd_en: 1'b1, src_1: s_1, src_2: s_2};
  endtask

  task automatic set_wb(input int l, input logic [REG_IDX_W-1:0] arn,
                        input logic [REG_IDX_W-1:0] rrn, input logic [XLEN-1:0] value);
    wb[l] = '{reg_write: 1'b1, arn: arn, rrn: rrn, result: value};
  endtask

  // one cycle: inputs are already driven on the falling edge, reads come back a cycle later
  task automatic step();
    rename_rsp_t exp_rsp;
    operand_t    exp_op [LANES];
    entry_t      e_1;
    entry_t      e_2;
    #1;
    check_ready(ren_ready, model_ready(), "ren_ready");
    for (int l = 0; l < LANES; l++) begin
      exp_rsp.rn       = lowest_free(l);
      exp_rsp.rs_1_map = lookup(ren_req[l].rs_1);
      exp_rsp.rs_2_map = lookup(ren_req[l].rs_2);
      check_rsp(ren_rsp[l], exp_rsp, $sformatf("rename lane %0d", l));
    end
    pend     = model_regs;
    rel_mask = '0;
    apply_wb();
    for (int l = 0; l < LANES; l++) begin
      e_1       = pend[rd_req[l].src_1];
      e_2       = pend[rd_req[l].src_2];
      exp_op[l] = '{data_1: e_1.value, valid_1: e_1.valid, data_2: e_2.value, valid_2: e_2.valid};
    end
    @(posedge global_bus);
    model_update();
    @(negedge global_bus);
    for (int l = 0; l < LANES; l++) begin
      if (rd_req[l].rd_en) begin
        model_op[l] = exp_op[l];
      end else begin
        model_op[l].valid_1 = 1'b0;  // data stays as last read
        model_op[l].valid_2 = 1'b0;
      end
      check_operand(rd_rsp[l], model_op[l], $sformatf("read lane %0d", l));
    end
    idle();
  endtask

  task automatic test_reset();
    check_ready(ren_ready, 1'b1, "ready after reset");
    for (int l = 0; l < LANES; l++) begin
      check_operand(rd_rsp[l], model_op[l], $sformatf("read lane %0d after reset", l));
    end
    for (int i = 0; i < ARCH_REGS; i += 4) begin
      set_read(0, REG_IDX_W'(i), REG_IDX_W'(i + 1));
      set_read(1, REG_IDX_W'(i + 2), REG_IDX_W'(i + 3));
      step();
    end
  endtask

  task automatic test_rename();
    set_ren(0, 1'b0, 5, 1, 2);
    set_ren(1, 1'b0, 7, 3, 4);
    step();
    set_lookup(0, 5, 7);
    set_lookup(1, 9, 5);  // 9 was never renamed
    step();
  endtask

  task automatic test_writeback();
    set_wb(0, 0, 32, $random(seed));
    set_wb(1, 0, 33, $random(seed));
    set_read(0, 32, 33);
    set_read(1, 33, 5);
    step();
    set_read(0, 32, 33);
    step();
  endtask

  task automatic test_commit();
    set_wb(0, 5, 32, $random(seed));
    step();
    set_lookup(0, 5, 7);
    set_read(0, 5, 32);
    step();
    set_ren(0, 1'b0, 7, 7, 8);  // 33 is still busy so lane 1 skips to 34
    set_ren(1, 1'b0, 8, 7, 8);
    step();
    set_wb(0, 7, 33, $random(seed));
    step();
    set_lookup(0, 7, 8);
    set_read(0, 7, 33);
    step();
  endtask

  task automatic test_tags();
    set_ren(0, 1'b1, 10, 0, 0);
    set_ren(1, 1'b1, 11, 0, 0);
    step();
    clear_tag = 1'b1;
    step();
    set_ren(0, 1'b1, 12, 10, 11);
    set_ren(1, 1'b1, 13, 10, 11);
    step();
    delete_tag = 1'b1;
    step();
    set_lookup(0, 12, 13);
    set_lookup(1, 10, 11);
    step();
  endtask

  task automatic test_exhaust();
    logic [REG_IDX_W-1:0] r;
    for (int c = 0; c < 16; c++) begin
      set_ren(0, 1'b0, rand_rd(), 1, 2);
      set_ren(1, 1'b0, rand_rd(), 3, 4);
      step();
    end
    check_ready(ren_ready, 1'b0, "ready after exhaustion");
    set_ren(0, 1'b0, 6, 6, 9);
    set_ren(1, 1'b0, 9, 6, 9);
    step();
    set_lookup(0, 6, 9);
    step();
    r = first_mapped();
    set_wb(0, r, model_regs[r].rrn, $random(seed));
    step();
    check_ready(ren_ready, 1'b0, "ready after one commit");
    r = first_mapped();
    set_wb(0, r, model_regs[r].rrn, $random(seed));
    step();
    check_ready(ren_ready, 1'b1, "ready after two commits");
    step();
  endtask

  initial begin
    seed       = 40;
    errors     = 0;
    checks     = 0;
    global_bus = 1'b0;
    rst_n      = 1'b0;
    idle();
    model_reset();
    repeat (2) @(posedge global_bus);
    @(negedge global_bus);
    rst_n = 1'b1;
    test_reset();
    test_rename();
    test_writeback();
    test_commit();
    test_tags();
    test_exhaust();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 100);
    $display("watchdog timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_pkg::*; (
  input  logic         global_bus,
  input  logic         rst_n,
  input  rename_req_t  ren_req [LANES],
  output rename_rsp_t  ren_rsp [LANES],
  output logic         ren_ready,
  input  wb_t          wb [LANES],
  input  operand_req_t rd_req [LANES],
  output operand_t     rd_rsp [LANES],
  input  logic         clear_tag,
  input  logic         delete_tag
);

  logic [REG_IDX_W-1:0] free_rn [LANES];
  logic [REN_REGS-1:0]  grab_mask;
  logic [REN_REGS-1:0]  release_mask;
  entry_t               entries_view [PHYS_REGS];

  rename_free_list u_free_list (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .grab_mask    (grab_mask),
    .release_mask (release_mask),
    .free_rn      (free_rn),
    .ren_ready    (ren_ready)
  );

  register_file u_register_file (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .ren_req      (ren_req),
    .ren_rsp      (ren_rsp),
    .free_rn      (free_rn),
    .ren_ready    (ren_ready),
    .wb           (wb),
    .clear_tag    (clear_tag),
    .delete_tag   (delete_tag),
    .grab_mask    (grab_mask),
    .release_mask (release_mask),
    .entries_view (entries_view)
  );

  // the same writeback bus feeds the read bypass
  operand_fetch u_operand_fetch (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .entries_view (entries_view),
    .wb           (wb),
    .rd_req       (rd_req),
    .rd_rsp       (rd_rsp)
  );

endmodule

`default_nettype wire

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import rename_pkg::*; (
  input  logic         global_bus,
  input  logic         rst_n,
  input  entry_t       entries_view [PHYS_REGS],
  input  wb_t          wb [LANES],
  input  operand_req_t rd_req [LANES],
  output operand_t     rd_rsp [LANES]
);

  // entry as the register file will hold it after this cycle's writebacks
  function automatic entry_t read_entry(input logic [REG_IDX_W-1:0] src);
    entry_t ent;
    ent = entries_view[src];
    for (int l = 0; l < LANES; l++) begin
      if (wb[l].reg_write && wb[l].arn == '0) begin
        if (wb[l].rrn == src) begin
          ent.value = wb[l].result;
          ent.valid = 1'b1;
        end
      end else if (wb[l].reg_write) begin
        if (wb[l].arn == src) begin
          ent.value = wb[l].result;
          ent.valid = 1'b1;
        end
        if (wb[l].rrn == src) begin  // committed rename entry gets zeroed
          ent.value = '0;
          ent.valid = 1'b0;
        end
      end
    end
    return ent;
  endfunction

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    entry_t ent_1;
    entry_t ent_2;

    always_comb begin
      ent_1 = read_entry(rd_req[l].src_1);
      ent_2 = read_entry(rd_req[l].src_2);
    end

    always_ff @(posedge global_bus or negedge rst_n) begin
      if (!rst_n) begin
        rd_rsp[l] <= '0;
      end else if (rd_req[l].rd_en) begin
        rd_rsp[l].data_1  <= ent_1.value;
        rd_rsp[l].valid_1 <= ent_1.valid;
        rd_rsp[l].data_2  <= ent_2.value;
        rd_rsp[l].valid_2 <= ent_2.valid;
      end else begin
        rd_rsp[l].valid_1 <= 1'b0;  // data keeps its old value
        rd_rsp[l].valid_2 <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import rename_pkg::*; (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  rename_req_t          ren_req [LANES],
  output rename_rsp_t          ren_rsp [LANES],
  input  logic [REG_IDX_W-1:0] free_rn [LANES],
  input  logic                 ren_ready,
  input  wb_t                  wb [LANES],
  input  logic                 clear_tag,
  input  logic                 delete_tag,
  output logic [REN_REGS-1:0]  grab_mask,
  output logic [REN_REGS-1:0]  release_mask,
  output entry_t               entries_view [PHYS_REGS]
);

  entry_t regs [PHYS_REGS];
  entry_t nxt  [PHYS_REGS];

  // lookups see the state before this cycle's renames
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      ren_rsp[l].rn = free_rn[l];
      ren_rsp[l].rs_1_map = (regs[ren_req[l].rs_1].rrn != '0) ?
                            regs[ren_req[l].rs_1].rrn : ren_req[l].rs_1;
      ren_rsp[l].rs_2_map = (regs[ren_req[l].rs_2].rrn != '0) ?
                            regs[ren_req[l].rs_2].rrn : ren_req[l].rs_2;
    end
  end

  always_comb begin
    nxt          = regs;
    grab_mask    = '0;
    release_mask = '0;

    // flushes act on the tags held before this cycle
    if (delete_tag) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        if (regs[i].tag) begin
          nxt[i].rrn = '0;  // back to the architectural value
          nxt[i].tag = 1'b0;
        end
      end
      for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
        if (regs[i].tag) begin
          nxt[i]                      = '0;
          release_mask[i - ARCH_REGS] = 1'b1;
        end
      end
    end else if (clear_tag) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        nxt[i].tag = 1'b0;
      end
    end

    // lane 1 comes last so it wins on a shared entry
    for (int l = 0; l < LANES; l++) begin
      if (wb[l].reg_write && wb[l].arn == '0) begin
        nxt[wb[l].rrn].value = wb[l].result;
        nxt[wb[l].rrn].valid = 1'b1;
      end else if (wb[l].reg_write) begin
        nxt[wb[l].arn].value = wb[l].result;
        nxt[wb[l].arn].valid = 1'b1;
        if (regs[wb[l].arn].rrn == wb[l].rrn) begin
          nxt[wb[l].arn].rrn = '0;
          nxt[wb[l].arn].tag = 1'b0;
        end
        nxt[wb[l].rrn] = '0;
        release_mask[wb[l].rrn[REG_IDX_W-2:0]] = 1'b1;
      end
    end

    // a rename after a commit of the same rd keeps the newer mapping
    for (int l = 0; l < LANES; l++) begin
      if (ren_req[l].valid && ren_ready) begin
        nxt[ren_req[l].rd].rrn = free_rn[l];
        nxt[ren_req[l].rd].tag = ren_req[l].tag;
        if (!ren_req[l].tag) begin
          nxt[ren_req[l].rd].valid = 1'b0;
        end
        nxt[free_rn[l]]     = '0;
        nxt[free_rn[l]].tag = ren_req[l].tag;
        grab_mask[free_rn[l][REG_IDX_W-2:0]] = 1'b1;
      end
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        regs[i] <= '{value: '0, rrn: '0, valid: (i < ARCH_REGS), tag: 1'b0};
      end
    end else begin
      regs <= nxt;
    end
  end

  assign entries_view = regs;

  for (genvar l = 0; l < LANES; l++) begin : g_check
    // the reorder buffer only ever commits out of rename entries
    a_commit_rrn: assert property (
      @(posedge global_bus) disable iff (!rst_n)
      (wb[l].reg_write && wb[l].arn != '0) |-> wb[l].rrn >= REG_IDX_W'(ARCH_REGS)
    ) else $error("commit on lane %0d names rrn %0d", l, wb[l].rrn);

    a_rename_rd: assert property (
      @(posedge global_bus) disable iff (!rst_n)
      (ren_req[l].valid && ren_ready) |-> ren_req[l].rd < REG_IDX_W'(ARCH_REGS)
    ) else $error("rename on lane %0d targets rd %0d", l, ren_req[l].rd);
  end

endmodule

`default_nettype wire

// ==== hdl/rename_free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_free_list import rename_pkg::*; (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic [REN_REGS-1:0]  grab_mask,
  input  logic [REN_REGS-1:0]  release_mask,
  output logic [REG_IDX_W-1:0] free_rn [LANES],
  output logic                 ren_ready
);

  logic [REN_REGS-1:0] free_map;  // one bit per rename register, set when free
  logic                found_0;
  logic                found_1;

  // pick the two lowest free bits, lane 0 gets the lower one
  always_comb begin
    found_0    = 1'b0;
    found_1    = 1'b0;
    free_rn[0] = '0;
    free_rn[1] = '0;
    for (int i = 0; i < REN_REGS; i++) begin
      if (free_map[i] && found_0 && !found_1) begin
        free_rn[1] = REG_IDX_W'(ARCH_REGS + i);
        found_1    = 1'b1;
      end
      if (free_map[i] && !found_0) begin
        free_rn[0] = REG_IDX_W'(ARCH_REGS + i);
        found_0    = 1'b1;
      end
    end
  end

  assign ren_ready = found_1;  // both lanes can always be served together

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      free_map <= '1;
    end else begin
      free_map <= (free_map & ~grab_mask) | release_mask;
    end
  end

  // the register file may only take numbers that were offered as free
  a_grab_free: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    (grab_mask & ~free_map) == '0
  ) else $error("rename register grabbed while not free");

  // a double release would hand the same number out twice
  a_release_busy: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    (release_mask & free_map) == '0
  ) else $error("rename register released while already free");

endmodule

`default_nettype wire

// ==== hdl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

  localparam int XLEN      = 32;
  localparam int ARCH_REGS = 32;
  localparam int REN_REGS  = 32;
  localparam int PHYS_REGS = 64;
  localparam int LANES     = 2;
  localparam int REG_IDX_W = 6;

  typedef struct packed {
    logic                 valid;
    logic                 tag;   // speculative instruction
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs_1;
    logic [REG_IDX_W-1:0] rs_2;
  } rename_req_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] rn;
    logic [REG_IDX_W-1:0] rs_1_map;
    logic [REG_IDX_W-1:0] rs_2_map;
  } rename_rsp_t;

  // arn of zero marks a result coming straight from execution
  typedef struct packed {
    logic                 reg_write;
    logic [REG_IDX_W-1:0] arn;
    logic [REG_IDX_W-1:0] rrn;
    logic [XLEN-1:0]      result;
  } wb_t;

  typedef struct packed {
    logic                 rd_en;
    logic [REG_IDX_W-1:0] src_1;
    logic [REG_IDX_W-1:0] src_2;
  } operand_req_t;

  typedef struct packed {
    logic [XLEN-1:0] data_1;
    logic            valid_1;
    logic [XLEN-1:0] data_2;
    logic            valid_2;
  } operand_t;

  typedef struct packed {
    logic [XLEN-1:0]      value;
    logic [REG_IDX_W-1:0] rrn;   // zero when the entry is not renamed
    logic                 valid;
    logic                 tag;
  } entry_t;

endpackage

`default_nettype wire
